// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // machine word, register index and instruction word.
    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] inst_t;

    // major opcodes of the supported subset.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // rv64 immediate shifts carry a 6-bit shamt, so only funct6 is checked.
    localparam logic [5:0] F6_BASE = 6'b000000;
    localparam logic [5:0] F6_SRA  = 6'b010000;

    // codes follow the mcause numbering.
    typedef enum logic [3:0] {
        TRAP_NONE    = 4'd0,
        TRAP_ILLEGAL = 4'd2
    } trap_e;

    localparam xlen_t RESET_PC = 64'h0000_0000_3000_0000;

endpackage

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS1,
        SRC_A_PC,
        SRC_A_ZERO
    } src_a_e;

    typedef enum logic {
        SRC_B_RS2,
        SRC_B_IMM
    } src_b_e;

    // decoded instruction as it sits between decode and execute.
    typedef struct packed {
        logic     valid;
        trap_e    trap;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     wb_en;
        alu_op_e  alu_op;
        src_a_e   src_a;
        src_b_e   src_b;
        xlen_t    imm;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
        xlen_t    pc;
        inst_t    inst;
    } id_exe_t;

    typedef struct packed {
        logic     valid;
        trap_e    trap;
        reg_idx_t rd;
        logic     wb_en;
        xlen_t    result;
        xlen_t    pc;
    } exe_ret_t;

    localparam id_exe_t ID_EXE_BUBBLE = '{
        valid: 1'b0, trap: TRAP_NONE, rd: '0, rs1: '0, rs2: '0, wb_en: 1'b0,
        alu_op: ALU_ADD, src_a: SRC_A_RS1, src_b: SRC_B_RS2, imm: '0,
        rs1_val: '0, rs2_val: '0, pc: RESET_PC, inst: '0
    };

    localparam exe_ret_t EXE_RET_BUBBLE = '{
        valid: 1'b0, trap: TRAP_NONE, rd: '0, wb_en: 1'b0, result: '0, pc: RESET_PC
    };

endpackage

// ==== hw/decode/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import rv_isa_pkg::*, pipe_pkg::*; (
    input  inst_t   inst,
    input  logic    valid,
    input  xlen_t   pc,
    output id_exe_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;
    xlen_t      i_imm;
    xlen_t      u_imm;
    logic       illegal;
    alu_op_e    op_sel;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign funct6 = inst[31:26];
    assign i_imm  = {{52{inst[31]}}, inst[31:20]};
    assign u_imm  = {{32{inst[31]}}, inst[31:12], 12'b0};

    // plain operation selected by funct3 alone.
    function automatic alu_op_e base_op(input logic [2:0] f3);
        case (f3)
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        illegal = 1'b0;
        op_sel  = base_op(funct3);
        dec     = ID_EXE_BUBBLE;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_ALT) begin
                    if (funct3 == F3_ADD_SUB) begin
                        op_sel = ALU_SUB;
                    end else if (funct3 == F3_SRL_SRA) begin
                        op_sel = ALU_SRA;
                    end else begin
                        illegal = 1'b1;
                    end
                end else if (funct7 != F7_BASE) begin
                    illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                dec.src_b = SRC_B_IMM;
                dec.imm   = i_imm;
                if (funct3 == F3_SLL && funct6 != F6_BASE) begin
                    illegal = 1'b1;
                end
                if (funct3 == F3_SRL_SRA) begin
                    if (funct6 == F6_SRA) begin
                        op_sel = ALU_SRA;
                    end else if (funct6 != F6_BASE) begin
                        illegal = 1'b1;
                    end
                end
            end
            OPC_LUI: begin
                dec.src_a = SRC_A_ZERO;
                dec.src_b = SRC_B_IMM;
                dec.imm   = u_imm;
                op_sel    = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                dec.src_a = SRC_A_PC;
                dec.src_b = SRC_B_IMM;
                dec.imm   = u_imm;
                op_sel    = ALU_ADD;
            end
            default: illegal = 1'b1;
        endcase

        dec.valid  = valid;
        dec.trap   = (valid && illegal) ? TRAP_ILLEGAL : TRAP_NONE;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        // x0 is never a write target, which also keeps it out of the bypass.
        dec.wb_en  = valid && !illegal && (inst[11:7] != '0);
        dec.alu_op = op_sel;
        dec.pc     = pc;
        dec.inst   = inst;
    end

endmodule

// ==== hw/decode/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    output xlen_t    rd1,
    output xlen_t    rd2,
    input  logic     we,
    input  reg_idx_t wa,
    input  xlen_t    wd
);

    xlen_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // reads are combinational. x0 ignores writes and so always reads zero.
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// ==== hw/decode/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass import rv_isa_pkg::*, pipe_pkg::*; (
    input  id_exe_t  dec,
    input  xlen_t    rf_rd1,
    input  xlen_t    rf_rd2,
    input  exe_ret_t exe_fwd,
    input  exe_ret_t ret_q,
    output id_exe_t  issue
);

    // the instruction in execute is younger than the one in retire, so it wins.
    function automatic xlen_t pick(
        input reg_idx_t src,
        input xlen_t    rf_val,
        input exe_ret_t younger,
        input exe_ret_t older
    );
        if (younger.valid && younger.wb_en && younger.rd == src) begin
            return younger.result;
        end else if (older.valid && older.wb_en && older.rd == src) begin
            return older.result;
        end
        return rf_val;
    endfunction

    always_comb begin
        issue         = dec;
        issue.rs1_val = pick(dec.rs1, rf_rd1, exe_fwd, ret_q);
        issue.rs2_val = pick(dec.rs2, rf_rd2, exe_fwd, ret_q);
    end

endmodule

// ==== hw/id_exe_reg.sv ====
`timescale 1ns/1ps

module id_exe_reg import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    enable,
    input  id_exe_t d,
    output id_exe_t q
);

    // the whole bundle moves as one word and freezes while enable is low.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= ID_EXE_BUBBLE;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

// ==== hw/execute/exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage import rv_isa_pkg::*, pipe_pkg::*; (
    input  id_exe_t  id,
    output exe_ret_t res
);

    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      alu_out;
    logic [5:0] shamt;

    always_comb begin
        case (id.src_a)
            SRC_A_PC:   op_a = id.pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = id.rs1_val;
        endcase
        op_b = (id.src_b == SRC_B_IMM) ? id.imm : id.rs2_val;
    end

    assign shamt = op_b[5:0];

    always_comb begin
        case (id.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SLT:    alu_out = {63'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {63'b0, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = xlen_t'($signed(op_a) >>> shamt);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        res.valid  = id.valid;
        res.trap   = id.trap;
        res.rd     = id.rd;
        res.wb_en  = id.wb_en;
        // a trapped instruction retires with a zero result.
        res.result = (id.trap == TRAP_NONE) ? alu_out : '0;
        res.pc     = id.pc;
    end

endmodule

// ==== hw/exe_ret_reg.sv ====
`timescale 1ns/1ps

module exe_ret_reg import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    input  exe_ret_t d,
    output exe_ret_t q
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= EXE_RET_BUBBLE;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

// ==== hw/int_pipe_top.sv ====
`timescale 1ns/1ps

module int_pipe_top import rv_isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    input  logic     in_valid,
    input  xlen_t    in_pc,
    input  inst_t    in_inst,
    output logic     ret_valid,
    output trap_e    ret_trap,
    output reg_idx_t ret_rd,
    output logic     ret_wb_en,
    output xlen_t    ret_result,
    output xlen_t    ret_pc
);

    id_exe_t  dec;
    id_exe_t  issue;
    id_exe_t  id_q;
    exe_ret_t exe_res;
    exe_ret_t ret_q;
    xlen_t    rf_rd1;
    xlen_t    rf_rd2;
    logic     rf_we;

    inst_decoder u_dec (.inst(in_inst), .valid(in_valid), .pc(in_pc), .dec(dec));

    // the retiring instruction writes back only on an enabled edge.
    assign rf_we = enable && ret_q.valid && ret_q.wb_en;

    reg_file u_rf (
        .clk(clk), .rst(rst), .ra1(dec.rs1), .ra2(dec.rs2), .rd1(rf_rd1), .rd2(rf_rd2),
        .we(rf_we), .wa(ret_q.rd), .wd(ret_q.result)
    );

    operand_bypass u_byp (
        .dec(dec), .rf_rd1(rf_rd1), .rf_rd2(rf_rd2),
        .exe_fwd(exe_res), .ret_q(ret_q), .issue(issue)
    );

    id_exe_reg u_id_exe (.clk(clk), .rst(rst), .enable(enable), .d(issue), .q(id_q));

    exe_stage u_exe (.id(id_q), .res(exe_res));

    exe_ret_reg u_exe_ret (.clk(clk), .rst(rst), .enable(enable), .d(exe_res), .q(ret_q));

    assign ret_valid  = ret_q.valid;
    assign ret_trap   = ret_q.trap;
    assign ret_rd     = ret_q.rd;
    assign ret_wb_en  = ret_q.wb_en;
    assign ret_result = ret_q.result;
    assign ret_pc     = ret_q.pc;

endmodule

// ==== verif/int_pipe_assertions.sv ====
`timescale 1ns/1ps

module int_pipe_assertions import rv_isa_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     enable,
    input logic     in_valid,
    input xlen_t    in_pc,
    input logic     ret_valid,
    input trap_e    ret_trap,
    input reg_idx_t ret_rd,
    input logic     ret_wb_en,
    input xlen_t    ret_result,
    input xlen_t    ret_pc
);

    typedef struct packed {
        logic  valid;
        xlen_t pc;
    } slot_t;

    int unsigned fail_count = 0;
    slot_t       slot1;
    slot_t       slot2;

    // pc history that advances on the same edges as the two pipeline registers.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot1 <= '0;
            slot2 <= '0;
        end else if (enable) begin
            slot1 <= '{valid: in_valid, pc: in_pc};
            slot2 <= slot1;
        end
    end

    reset_values: assert property (@(posedge clk)
        (rst || $fell(rst)) |-> (!ret_valid && !ret_wb_en && ret_pc == RESET_PC))
    else begin
        fail_count++;
        $error("retire outputs are not at their reset values");
    end

    two_edge_latency: assert property (@(posedge clk) disable iff (rst)
        (ret_valid == slot2.valid) && (!ret_valid || ret_pc == slot2.pc))
    else begin
        fail_count++;
        $error("retired pc %h does not match the instruction accepted two edges earlier",
               ret_pc);
    end

    hold_when_disabled: assert property (@(posedge clk) disable iff (rst)
        !$past(enable) |-> $stable({ret_valid, ret_trap, ret_rd, ret_wb_en, ret_result, ret_pc}))
    else begin
        fail_count++;
        $error("retire outputs changed while enable was low");
    end

    trap_blocks_write: assert property (@(posedge clk) disable iff (rst)
        (ret_valid && ret_trap != TRAP_NONE) |-> !ret_wb_en)
    else begin
        fail_count++;
        $error("a trapped instruction retired with its write enable set");
    end

    x0_never_written: assert property (@(posedge clk) disable iff (rst)
        (ret_valid && ret_rd == '0) |-> !ret_wb_en)
    else begin
        fail_count++;
        $error("an instruction with rd equal to x0 retired with its write enable set");
    end

endmodule

bind int_pipe_top int_pipe_assertions u_assertions (.*);

// ==== verif/int_pipe_tb.sv ====
`timescale 1ns/1ps

module int_pipe_tb import rv_isa_pkg::*; ();

    localparam int          CLK_PERIOD = 10;
    localparam int          NUM_INSTS  = 400;
    localparam logic [31:0] LFSR_SEED  = 32'h80e7_4aa2;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        logic     wb_en;
        trap_e    trap;
        xlen_t    result;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        enable;
    logic        in_valid;
    xlen_t       in_pc;
    inst_t       in_inst;
    logic        ret_valid;
    trap_e       ret_trap;
    reg_idx_t    ret_rd;
    logic        ret_wb_en;
    xlen_t       ret_result;
    xlen_t       ret_pc;
    logic [31:0] lfsr;
    xlen_t       model_regs [32];
    expect_t     exp_q [$];
    int          err_count;
    int          ret_count;
    xlen_t       next_pc;
    logic        bubble;

    int_pipe_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois lfsr stepped once for every bit handed out.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    // registers are drawn from x0..x7 so that dependent neighbours are common.
    function automatic inst_t gen_inst();
        logic [3:0]  cls;
        logic [2:0]  f3;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [11:0] imm;
        cls = 4'(rand_bits(4));
        f3  = 3'(rand_bits(3));
        rd  = reg_idx_t'(rand_bits(3));
        rs1 = reg_idx_t'(rand_bits(3));
        rs2 = reg_idx_t'(rand_bits(3));
        imm = 12'(rand_bits(12));
        if (cls < 4'd6) begin
            if ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) != 0) begin
                return {7'h20, rs2, rs1, f3, rd, OPC_OP};
            end
            return {7'h00, rs2, rs1, f3, rd, OPC_OP};
        end else if (cls < 4'd11) begin
            if (f3 == 3'd1) begin
                imm[11:6] = 6'b000000;
            end else if (f3 == 3'd5) begin
                imm[11:6] = (rand_bits(1) != 0) ? 6'b010000 : 6'b000000;
            end
            return {imm, rs1, f3, rd, OPC_OP_IMM};
        end else if (cls < 4'd13) begin
            return {20'(rand_bits(20)), rd, OPC_LUI};
        end else if (cls < 4'd15) begin
            return {20'(rand_bits(20)), rd, OPC_AUIPC};
        end
        case (2'(rand_bits(2)))
            2'd0:    return {25'(rand_bits(25)), 7'b0000011};
            2'd1:    return {7'h01, rs2, rs1, f3, rd, OPC_OP};
            2'd2:    return {6'b100000, imm[5:0], rs1, 3'b001, rd, OPC_OP_IMM};
            default: return {25'(rand_bits(25)), 7'b1101111};
        endcase
    endfunction

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return {63'b0, $signed(a) < $signed(b)};
            3'd3:    return {63'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA semantics of one instruction against the model register state.
    function automatic void ref_exec(input inst_t w, input xlen_t pc,
                                     output logic legal, output xlen_t res);
        xlen_t a;
        xlen_t imm_i;
        xlen_t imm_u;
        logic  alt;
        a     = model_regs[w[19:15]];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_u = {{32{w[31]}}, w[31:12], 12'b0};
        alt   = 1'b0;
        legal = 1'b1;
        res   = '0;
        case (w[6:0])
            OPC_OP: begin
                if (w[31:25] == 7'h20 && (w[14:12] == 3'd0 || w[14:12] == 3'd5)) begin
                    alt = 1'b1;
                end else if (w[31:25] != 7'h00) begin
                    legal = 1'b0;
                end
                res = alu_ref(w[14:12], alt, a, model_regs[w[24:20]]);
            end
            OPC_OP_IMM: begin
                if (w[14:12] == 3'd1 && w[31:26] != 6'b000000) begin
                    legal = 1'b0;
                end
                if (w[14:12] == 3'd5) begin
                    if (w[31:26] == 6'b010000) begin
                        alt = 1'b1;
                    end else if (w[31:26] != 6'b000000) begin
                        legal = 1'b0;
                    end
                end
                res = alu_ref(w[14:12], alt, a, imm_i);
            end
            OPC_LUI:   res = imm_u;
            OPC_AUIPC: res = pc + imm_u;
            default:   legal = 1'b0;
        endcase
    endfunction

    task automatic compare_value(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            err_count++;
            $display("Error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic accept_inst();
        expect_t e;
        logic    legal;
        xlen_t   res;
        ref_exec(in_inst, in_pc, legal, res);
        e.pc     = in_pc;
        e.rd     = in_inst[11:7];
        e.trap   = legal ? TRAP_NONE : TRAP_ILLEGAL;
        e.wb_en  = legal && (in_inst[11:7] != '0);
        e.result = res;
        if (e.wb_en) begin
            model_regs[e.rd] = res;
        end
        exp_q.push_back(e);
    endtask

    task automatic check_retire();
        expect_t e;
        ret_count++;
        if (exp_q.size() == 0) begin
            err_count++;
            $display("Error: time %0t, an instruction retired with none outstanding", $time);
        end else begin
            e = exp_q.pop_front();
            compare_value("ret_pc", e.pc, ret_pc);
            compare_value("ret_rd", xlen_t'(e.rd), xlen_t'(ret_rd));
            compare_value("ret_trap", xlen_t'(e.trap), xlen_t'(ret_trap));
            compare_value("ret_wb_en", xlen_t'(e.wb_en), xlen_t'(ret_wb_en));
            if (e.trap == TRAP_NONE) begin
                compare_value("ret_result", e.result, ret_result);
            end
        end
    endtask

    // values read here are the ones the DUT sees at this edge.
    always @(posedge clk) begin
        if (!rst && enable) begin
            if (ret_valid) begin
                check_retire();
            end
            if (in_valid) begin
                accept_inst();
            end
        end
    end

    initial begin
        #(20 * NUM_INSTS * CLK_PERIOD);
        $display("Error: watchdog expired before the pipeline drained, %0d still outstanding",
                 exp_q.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        enable    = 1'b0;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_inst   = '0;
        lfsr      = LFSR_SEED;
        err_count = 0;
        ret_count = 0;
        next_pc   = 64'h0000_0000_8000_0000;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        #1 rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < NUM_INSTS; n++) begin
            bubble = (rand_bits(3) == 0);
            in_valid <= !bubble;
            in_inst  <= gen_inst();
            in_pc    <= next_pc;
            enable   <= 1'b1;
            if (!bubble) begin
                next_pc = next_pc + 64'd4;
            end
            @(posedge clk);
            if (rand_bits(2) == 0) begin
                enable <= 1'b0;
                repeat (1 + rand_bits(2)) @(posedge clk);
            end
        end
        in_valid <= 1'b0;
        enable   <= 1'b1;
        @(negedge clk);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        $display("Retired %0d instructions, %0d compare errors, %0d assertion failures",
                 ret_count, err_count, DUT.u_assertions.fail_count);
        if (err_count == 0 && DUT.u_assertions.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
common/rv_isa_pkg.sv
common/pipe_pkg.sv
hw/decode/inst_decoder.sv
hw/decode/reg_file.sv
hw/decode/operand_bypass.sv
hw/id_exe_reg.sv
hw/execute/exe_stage.sv
hw/exe_ret_reg.sv
hw/int_pipe_top.sv
verif/int_pipe_assertions.sv
verif/int_pipe_tb.sv
